// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_audio_spi
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and pass only if the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: audio_spi_pkg.sv
`default_nettype none

package audio_spi_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int NUM_FILTERS    = 4;
    localparam int MAX_TAPS       = 32;
    localparam int FILT_W         = $clog2(NUM_FILTERS);   // 2
    localparam int TAP_W          = $clog2(MAX_TAPS);      // 5
    localparam int COEF_AW        = FILT_W + TAP_W;        // Flat coef memory address
    localparam int SPI_FRAME_BITS = 16;
    localparam int BIT_CNT_W      = $clog2(SPI_FRAME_BITS);

    typedef logic [6:0]        reg_addr_t;    // Register address, below the R/W flag
    typedef logic [7:0]        reg_data_t;
    typedef logic [15:0]       coef_t;        // {msb, lsb}
    typedef logic [FILT_W-1:0] filt_idx_t;
    typedef logic [TAP_W-1:0]  tap_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////
    localparam reg_addr_t ADDR_AUD_CONTROL     = 7'h00;
    localparam reg_addr_t ADDR_STATUS          = 7'h01;  // Read only, from outside
    localparam reg_addr_t ADDR_TAPS_PER_FILTER = 7'h02;
    localparam reg_addr_t ADDR_FILTER_SEL      = 7'h03;
    localparam reg_addr_t ADDR_FIR_COEF_LSB    = 7'h04;  // Write only
    localparam reg_addr_t ADDR_FIR_COEF_MSB    = 7'h05;  // Write only, commits the pair
    localparam reg_addr_t ADDR_AUX             = 7'h06;
    localparam reg_addr_t ADDR_SRAM_CONTROL    = 7'h07;
    localparam reg_addr_t ADDR_SRAM_START_ADDR = 7'h08;
    localparam reg_addr_t ADDR_SPI_TO_SRAM     = 7'h09;
    localparam reg_addr_t ADDR_SRAM_TO_SPI     = 7'h0A;  // Read only
    localparam reg_addr_t ADDR_MPIO_CONTROL    = 7'h0B;
    localparam reg_addr_t ADDR_SPI_TO_MPIO     = 7'h0C;
    localparam reg_addr_t ADDR_MPIO_TO_SPI     = 7'h0D;  // Read only
    localparam reg_addr_t ADDR_EQ_GAIN_LSB     = 7'h0E;  // Write only
    localparam reg_addr_t ADDR_EQ_GAIN_MSB     = 7'h0F;  // Write only, commits the pair

    localparam reg_data_t READ_DEFAULT = 8'hC3;  // Unreadable or unmapped

    // Serial engine states
    typedef enum logic [1:0] {
        IDLE,   // cs high
        CMD,    // R/W flag and address
        DATA,   // Data byte
        DONE    // Frame complete, wait for cs
    } spi_state_t;

endpackage

`default_nettype wire

// File: audio_spi_top.sv
`timescale 1ns/1ns
`default_nettype none

// SPI control front end for the audio filter processor
module audio_spi_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     spi_cs,
    input  logic                     spi_clk,
    input  logic                     spi_mosi,
    output logic                     spi_miso,
    output logic                     spi_miso_oe,   // Stands in for a tri-state pad
    input  audio_spi_pkg::reg_data_t status,
    input  audio_spi_pkg::reg_data_t sram_to_spi_data,
    input  audio_spi_pkg::reg_data_t mpio_to_spi_data,
    input  audio_spi_pkg::filt_idx_t rd_filter,     // Filter datapath read port
    input  audio_spi_pkg::tap_idx_t  rd_tap,
    output audio_spi_pkg::coef_t     coef_rd,
    output audio_spi_pkg::coef_t     gain_rd,
    output audio_spi_pkg::reg_data_t audio_control,
    output audio_spi_pkg::reg_data_t taps_per_filter,
    output audio_spi_pkg::reg_data_t filter_sel,
    output audio_spi_pkg::reg_data_t aux,
    output audio_spi_pkg::reg_data_t sram_control,
    output audio_spi_pkg::reg_data_t sram_start_addr,
    output audio_spi_pkg::reg_data_t spi_to_sram,
    output audio_spi_pkg::reg_data_t mpio_control,
    output audio_spi_pkg::reg_data_t spi_to_mpio
);
    import audio_spi_pkg::*;

    reg_data_t coef_lsb;     // Bank to store
    reg_data_t coef_msb;
    reg_data_t eq_lsb;
    reg_data_t eq_msb;
    logic      coef_wr_stb;
    logic      eq_wr_stb;
    logic      sel_wr_stb;

    spi_bus_if bus ();

    spi_slave spi_slave_i (
        .clk, .rst_n, .spi_cs, .spi_clk, .spi_mosi, .spi_miso, .spi_miso_oe,
        .bus (bus.slave_mp)
    );

    spi_reg_bank spi_reg_bank_i (
        .clk, .rst_n,
        .bus (bus.regs_mp),
        .status, .sram_to_spi_data, .mpio_to_spi_data,
        .audio_control, .taps_per_filter, .filter_sel,
        .coef_lsb, .coef_msb, .eq_lsb, .eq_msb, .aux,
        .sram_control, .sram_start_addr, .spi_to_sram,
        .mpio_control, .spi_to_mpio,
        .coef_wr_stb, .eq_wr_stb, .sel_wr_stb
    );

    coef_store coef_store_i (
        .clk, .rst_n, .coef_wr_stb, .eq_wr_stb, .sel_wr_stb,
        .filter_sel, .taps_per_filter, .coef_lsb, .coef_msb, .eq_lsb, .eq_msb,
        .rd_filter, .rd_tap, .coef_rd, .gain_rd
    );

endmodule

`default_nettype wire

// File: coef_store.sv
`timescale 1ns/1ns
`default_nettype none

// FIR coefficient and EQ gain memories with auto-incrementing tap pointer
module coef_store (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     coef_wr_stb,
    input  logic                     eq_wr_stb,
    input  logic                     sel_wr_stb,
    input  audio_spi_pkg::reg_data_t filter_sel,
    input  audio_spi_pkg::reg_data_t taps_per_filter,
    input  audio_spi_pkg::reg_data_t coef_lsb,
    input  audio_spi_pkg::reg_data_t coef_msb,
    input  audio_spi_pkg::reg_data_t eq_lsb,
    input  audio_spi_pkg::reg_data_t eq_msb,
    input  audio_spi_pkg::filt_idx_t rd_filter,
    input  audio_spi_pkg::tap_idx_t  rd_tap,
    output audio_spi_pkg::coef_t     coef_rd,
    output audio_spi_pkg::coef_t     gain_rd
);
    import audio_spi_pkg::*;

    coef_t            coef_mem [NUM_FILTERS*MAX_TAPS];  // {filter, tap}
    coef_t            gain_mem [NUM_FILTERS];
    filt_idx_t        wr_filter;
    tap_idx_t         tap_ptr;
    reg_data_t        tap_limit;   // Effective taps, 1..MAX_TAPS
    logic [COEF_AW:0] clr_cnt;     // MSB set when clear done
    logic             clearing;

    assign wr_filter = filter_sel[FILT_W-1:0];  // Low bits only
    assign tap_limit = (taps_per_filter == '0 || taps_per_filter > reg_data_t'(MAX_TAPS))
                     ? reg_data_t'(MAX_TAPS) : taps_per_filter;
    assign clearing  = !clr_cnt[COEF_AW];

    // Post-reset clear, one word per clk
    always_ff @(posedge clk) begin
        if (!rst_n)
            clr_cnt <= '0;
        else if (clearing)
            clr_cnt <= clr_cnt + 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tap pointer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tap_ptr <= '0;
        end else if (sel_wr_stb) begin
            tap_ptr <= '0;  // New filter starts at tap 0
        end else if (coef_wr_stb) begin
            if (reg_data_t'(tap_ptr) + 1'b1 >= tap_limit)
                tap_ptr <= '0;  // Wrap
            else
                tap_ptr <= tap_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memories, write and registered read
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (clearing) begin
            coef_mem[clr_cnt[COEF_AW-1:0]] <= '0;
            gain_mem[clr_cnt[FILT_W-1:0]]  <= '0;
        end else begin
            if (coef_wr_stb)
                coef_mem[{wr_filter, tap_ptr}] <= {coef_msb, coef_lsb};
            if (eq_wr_stb)
                gain_mem[wr_filter] <= {eq_msb, eq_lsb};
        end
        coef_rd <= coef_mem[{rd_filter, rd_tap}];  // 1 clk latency
        gain_rd <= gain_mem[rd_filter];
    end

    // Pointer stays inside the programmed taps, hence below MAX_TAPS
    assert property (@(posedge clk) disable iff (!rst_n)
        coef_wr_stb |=> (reg_data_t'(tap_ptr) < tap_limit));

endmodule

`default_nettype wire

// File: flist.f
audio_spi_pkg.sv
spi_bus_if.sv
spi_slave.sv
spi_reg_bank.sv
coef_store.sv
audio_spi_top.sv
tb_clk_gen.sv
tb_audio_spi.sv

// File: spi_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

// Register access between serial engine and register bank
interface spi_bus_if;
    import audio_spi_pkg::*;

    logic      rd_stb;  // One clk, read frame after address byte
    logic      wr_stb;  // One clk, write frame after data byte
    reg_addr_t addr;    // Held until next frame
    reg_data_t wdata;
    reg_data_t rdata;   // Combinational from addr

    modport slave_mp (
        output rd_stb,
        output wr_stb,
        output addr,
        output wdata,
        input  rdata
    );

    // Bank decodes from addr alone, no use for rd_stb
    modport regs_mp (
        input  wr_stb,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: spi_reg_bank.sv
`timescale 1ns/1ns
`default_nettype none

// Control register bank, read mux and coefficient strobes
module spi_reg_bank (
    input  logic                     clk,
    input  logic                     rst_n,
    spi_bus_if.regs_mp               bus,
    input  audio_spi_pkg::reg_data_t status,
    input  audio_spi_pkg::reg_data_t sram_to_spi_data,
    input  audio_spi_pkg::reg_data_t mpio_to_spi_data,
    output audio_spi_pkg::reg_data_t audio_control,
    output audio_spi_pkg::reg_data_t taps_per_filter,
    output audio_spi_pkg::reg_data_t filter_sel,
    output audio_spi_pkg::reg_data_t coef_lsb,
    output audio_spi_pkg::reg_data_t coef_msb,
    output audio_spi_pkg::reg_data_t eq_lsb,
    output audio_spi_pkg::reg_data_t eq_msb,
    output audio_spi_pkg::reg_data_t aux,
    output audio_spi_pkg::reg_data_t sram_control,
    output audio_spi_pkg::reg_data_t sram_start_addr,
    output audio_spi_pkg::reg_data_t spi_to_sram,
    output audio_spi_pkg::reg_data_t mpio_control,
    output audio_spi_pkg::reg_data_t spi_to_mpio,
    output logic                     coef_wr_stb,
    output logic                     eq_wr_stb,
    output logic                     sel_wr_stb
);
    import audio_spi_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            audio_control   <= '0;
            taps_per_filter <= '0;
            filter_sel      <= '0;
            coef_lsb        <= '0;
            coef_msb        <= '0;
            eq_lsb          <= '0;
            eq_msb          <= '0;
            aux             <= '0;
            sram_control    <= '0;
            sram_start_addr <= '0;
            spi_to_sram     <= '0;
            mpio_control    <= '0;
            spi_to_mpio     <= '0;
        end else if (bus.wr_stb) begin
            case (bus.addr)
                ADDR_AUD_CONTROL:     audio_control   <= bus.wdata;
                ADDR_TAPS_PER_FILTER: taps_per_filter <= bus.wdata;
                ADDR_FILTER_SEL:      filter_sel      <= bus.wdata;
                ADDR_FIR_COEF_LSB:    coef_lsb        <= bus.wdata;
                ADDR_FIR_COEF_MSB:    coef_msb        <= bus.wdata;
                ADDR_EQ_GAIN_LSB:     eq_lsb          <= bus.wdata;
                ADDR_EQ_GAIN_MSB:     eq_msb          <= bus.wdata;
                ADDR_AUX:             aux             <= bus.wdata;
                ADDR_SRAM_CONTROL:    sram_control    <= bus.wdata;
                ADDR_SRAM_START_ADDR: sram_start_addr <= bus.wdata;
                ADDR_SPI_TO_SRAM:     spi_to_sram     <= bus.wdata;
                ADDR_MPIO_CONTROL:    mpio_control    <= bus.wdata;
                ADDR_SPI_TO_MPIO:     spi_to_mpio     <= bus.wdata;
                default: ;  // Read-only and unmapped writes dropped
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read mux, sampled by the slave with rd_stb
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (bus.addr)
            ADDR_AUD_CONTROL:     bus.rdata = audio_control;
            ADDR_STATUS:          bus.rdata = status;
            ADDR_TAPS_PER_FILTER: bus.rdata = taps_per_filter;
            ADDR_FILTER_SEL:      bus.rdata = filter_sel;
            ADDR_AUX:             bus.rdata = aux;
            ADDR_SRAM_CONTROL:    bus.rdata = sram_control;
            ADDR_SRAM_START_ADDR: bus.rdata = sram_start_addr;
            ADDR_SPI_TO_SRAM:     bus.rdata = spi_to_sram;
            ADDR_SRAM_TO_SPI:     bus.rdata = sram_to_spi_data;
            ADDR_MPIO_CONTROL:    bus.rdata = mpio_control;
            ADDR_SPI_TO_MPIO:     bus.rdata = spi_to_mpio;
            ADDR_MPIO_TO_SPI:     bus.rdata = mpio_to_spi_data;
            default:              bus.rdata = READ_DEFAULT;  // Coef and gain too
        endcase
    end

    // Store strobes, same cycle as the register update
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            coef_wr_stb <= 1'b0;
            eq_wr_stb   <= 1'b0;
            sel_wr_stb  <= 1'b0;
        end else begin
            coef_wr_stb <= bus.wr_stb && (bus.addr == ADDR_FIR_COEF_MSB);  // MSB commits
            eq_wr_stb   <= bus.wr_stb && (bus.addr == ADDR_EQ_GAIN_MSB);
            sel_wr_stb  <= bus.wr_stb && (bus.addr == ADDR_FILTER_SEL);    // Restart taps
        end
    end

    // At most one store operation per cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({coef_wr_stb, eq_wr_stb, sel_wr_stb}));

endmodule

`default_nettype wire

// File: spi_slave.sv
`timescale 1ns/1ns
`default_nettype none

// SPI mode 0 slave, 16-bit frames, MSB first, oversampled in clk
module spi_slave (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        spi_cs,
    input  logic        spi_clk,
    input  logic        spi_mosi,
    output logic        spi_miso,
    output logic        spi_miso_oe,
    spi_bus_if.slave_mp bus
);
    import audio_spi_pkg::*;

    logic [2:0]           sck_sync;   // Two sync flops plus one for edges
    logic [1:0]           cs_sync;
    logic [1:0]           mosi_sync;
    logic                 sck_rise;
    logic                 sck_fall;
    logic                 cs_low;
    logic                 mosi_bit;
    spi_state_t           state;
    logic [BIT_CNT_W-1:0] bit_cnt;    // Rising edges seen in frame
    logic [6:0]           shift_in;   // Eighth bit taken straight from mosi
    reg_data_t            shift_out;
    logic                 rd_flag;    // Latched R/W bit

    ////////////////////////////////////////////////////////////////////////////
    // Pin synchronizers and edge detect
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck_sync  <= '0;
            cs_sync   <= '1;  // Deselected
            mosi_sync <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], spi_clk};
            cs_sync   <= {cs_sync[0], spi_cs};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_sync[2];
    assign sck_fall = ~sck_sync[1] & sck_sync[2];
    assign cs_low   = ~cs_sync[1];
    assign mosi_bit = mosi_sync[1];

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM, shift in and strobes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            shift_in   <= '0;
            rd_flag    <= 1'b0;
            bus.rd_stb <= 1'b0;
            bus.wr_stb <= 1'b0;
            bus.addr   <= '0;
            bus.wdata  <= '0;
        end else begin
            bus.rd_stb <= 1'b0;  // Pulses
            bus.wr_stb <= 1'b0;
            if (!cs_low) begin
                state   <= IDLE;  // Also aborts a short frame
                bit_cnt <= '0;
            end else begin
                if (state == IDLE)
                    state <= CMD;
                if (sck_rise) begin
                    shift_in <= {shift_in[5:0], mosi_bit};
                    bit_cnt  <= bit_cnt + 1'b1;
                    case (state)
                        CMD: begin
                            if (bit_cnt == BIT_CNT_W'(SPI_FRAME_BITS / 2 - 1)) begin
                                state      <= DATA;
                                rd_flag    <= shift_in[6];  // First bit of frame
                                bus.addr   <= {shift_in[5:0], mosi_bit};
                                bus.rd_stb <= shift_in[6];
                            end
                        end
                        DATA: begin
                            if (bit_cnt == BIT_CNT_W'(SPI_FRAME_BITS - 1)) begin
                                state <= DONE;
                                if (!rd_flag) begin
                                    bus.wdata  <= {shift_in[6:0], mosi_bit};
                                    bus.wr_stb <= 1'b1;
                                end
                            end
                        end
                        default: ;  // Extra clocks after bit 16 ignored
                    endcase
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data out on falling edges
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_out <= '0;
            spi_miso  <= 1'b0;
        end else if (bus.rd_stb) begin
            shift_out <= bus.rdata;  // Bank data valid with the strobe
        end else if (sck_fall && state == DATA) begin
            spi_miso  <= shift_out[7];  // MSB on 8th falling edge
            shift_out <= {shift_out[6:0], 1'b0};
        end
    end

    // Driven only for a read data byte, never with cs high
    assign spi_miso_oe = rd_flag && (state == DATA) && !spi_cs;

    // Read and write frames are exclusive
    assert property (@(posedge clk) disable iff (!rst_n) !(bus.rd_stb && bus.wr_stb));

    // Write only from a frame still selected at bit 16
    assert property (@(posedge clk) disable iff (!rst_n) bus.wr_stb |-> cs_low);

endmodule

`default_nettype wire

// File: tb_audio_spi.sv
`timescale 1ns/1ns
`default_nettype none

module tb_audio_spi;
    import audio_spi_pkg::*;

    localparam int HALF_SCK    = 8;   // clk per SCK half-period
    localparam int N_RW_WRITES = 20;
    localparam int N_UNMAPPED  = 6;
    localparam int WRAP_TAPS   = 5;
    localparam int COEF_PAIRS  = 6;   // One past the tap count, forces a wrap
    localparam int ZERO_PAIRS  = 7;   // Past the old tap count with taps = 0
    localparam int NUM_FRAMES  = 16 + 2 * N_RW_WRITES + 10 + 2 * N_UNMAPPED
                               + 3 + NUM_FILTERS * (1 + 2 * COEF_PAIRS) + 2 * ZERO_PAIRS
                               + 3 * NUM_FILTERS + 2;
    // 16 SCK periods per frame, doubled, plus memory clear and store sweeps
    localparam int WATCHDOG_CLKS = NUM_FRAMES * 16 * (2 * HALF_SCK) * 2
                                 + 32 * NUM_FILTERS * MAX_TAPS;
    localparam reg_addr_t RW_ADDRS [9] = '{ADDR_AUD_CONTROL, ADDR_TAPS_PER_FILTER,
        ADDR_FILTER_SEL, ADDR_AUX, ADDR_SRAM_CONTROL, ADDR_SRAM_START_ADDR,
        ADDR_SPI_TO_SRAM, ADDR_MPIO_CONTROL, ADDR_SPI_TO_MPIO};

    logic      clk, rst_n;
    logic      spi_cs, spi_clk, spi_mosi, spi_miso, spi_miso_oe;
    reg_data_t status, sram_to_spi_data, mpio_to_spi_data;
    filt_idx_t rd_filter;
    tap_idx_t  rd_tap;
    coef_t     coef_rd, gain_rd;
    reg_data_t audio_control, taps_per_filter, filter_sel, aux, sram_control;
    reg_data_t sram_start_addr, spi_to_sram, mpio_control, spi_to_mpio;

    reg_data_t   model_regs [16];                    // Reference register file
    coef_t       model_coef [NUM_FILTERS][MAX_TAPS];
    coef_t       model_gain [NUM_FILTERS];
    int          model_ptr;                          // Reference tap pointer
    integer      seed = 33;
    int          errors = 0;
    string       name_q [$];                         // Pending compares
    logic [15:0] exp_q [$];
    logic [15:0] act_q [$];

    tb_clk_gen clk_gen_i (.clk, .rst_n);

    audio_spi_top audio_spi_top_i (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic void model_write(reg_addr_t a, reg_data_t d);
        int limit;
        int f;
        if (a < 7'h10 && a != ADDR_STATUS && a != ADDR_SRAM_TO_SPI && a != ADDR_MPIO_TO_SPI)
            model_regs[a[3:0]] = d;
        f     = int'(model_regs[ADDR_FILTER_SEL][FILT_W-1:0]);  // Low bits pick filter
        limit = int'(model_regs[ADDR_TAPS_PER_FILTER]);
        if (limit == 0 || limit > MAX_TAPS)
            limit = MAX_TAPS;
        if (a == ADDR_FILTER_SEL)
            model_ptr = 0;
        if (a == ADDR_FIR_COEF_MSB) begin
            model_coef[f][model_ptr] = {d, model_regs[ADDR_FIR_COEF_LSB]};
            model_ptr = (model_ptr + 1 >= limit) ? 0 : model_ptr + 1;
        end
        if (a == ADDR_EQ_GAIN_MSB)
            model_gain[f] = {d, model_regs[ADDR_EQ_GAIN_LSB]};
    endfunction

    function automatic reg_data_t expected_read(reg_addr_t a);
        case (a)
            ADDR_STATUS:      return status;
            ADDR_SRAM_TO_SPI: return sram_to_spi_data;
            ADDR_MPIO_TO_SPI: return mpio_to_spi_data;
            ADDR_FIR_COEF_LSB, ADDR_FIR_COEF_MSB,
            ADDR_EQ_GAIN_LSB, ADDR_EQ_GAIN_MSB: return READ_DEFAULT;  // Write only
            default: return (a < 7'h10) ? model_regs[a[3:0]] : READ_DEFAULT;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic queue_compare(string name, logic [15:0] expected, logic [15:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endtask

    always @(posedge clk) begin
        while (exp_q.size() != 0)
            check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end

    always @(posedge clk) begin
        if (rst_n && spi_cs && spi_miso_oe) begin
            $display("spi_miso_oe went high while cs was high");
            stop_with_failure();
        end
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("timeout: frames did not finish");
        stop_with_failure();
    end

    ////////////////////////////////////////////////////////////////////////////
    // SPI master, mode 0, MSB first
    ////////////////////////////////////////////////////////////////////////////
    task automatic spi_frame(input logic [15:0] tx, input int nbits, output reg_data_t rx);
        rx = '0;
        @(posedge clk);
        spi_cs <= 1'b0;
        for (int i = 0; i < nbits; i++) begin
            spi_mosi <= tx[15-i];             // Changes with SCK falling
            repeat (HALF_SCK) @(posedge clk);
            spi_clk <= 1'b1;
            if (i >= 8)
                rx = {rx[6:0], spi_miso};     // Data byte sampled on rise
            repeat (HALF_SCK) @(posedge clk);
            spi_clk <= 1'b0;
        end
        repeat (HALF_SCK) @(posedge clk);
        spi_cs <= 1'b1;                       // Early rise aborts the frame
        repeat (2 * HALF_SCK) @(posedge clk);
    endtask

    task automatic reg_write(reg_addr_t a, reg_data_t d);
        reg_data_t unused;
        spi_frame({1'b0, a, d}, 16, unused);
        model_write(a, d);
    endtask

    task automatic reg_read(string name, reg_addr_t a);
        reg_data_t rx;
        spi_frame({1'b1, a, 8'h00}, 16, rx);
        queue_compare(name, expected_read(a), rx);
    endtask

    task automatic compare_outputs(string name);
        queue_compare({name, " audio_control"}, model_regs[ADDR_AUD_CONTROL], audio_control);
        queue_compare({name, " taps"}, model_regs[ADDR_TAPS_PER_FILTER], taps_per_filter);
        queue_compare({name, " filter_sel"}, model_regs[ADDR_FILTER_SEL], filter_sel);
        queue_compare({name, " aux"}, model_regs[ADDR_AUX], aux);
        queue_compare({name, " sram_control"}, model_regs[ADDR_SRAM_CONTROL], sram_control);
        queue_compare({name, " sram_start"}, model_regs[ADDR_SRAM_START_ADDR], sram_start_addr);
        queue_compare({name, " spi_to_sram"}, model_regs[ADDR_SPI_TO_SRAM], spi_to_sram);
        queue_compare({name, " mpio_control"}, model_regs[ADDR_MPIO_CONTROL], mpio_control);
        queue_compare({name, " spi_to_mpio"}, model_regs[ADDR_SPI_TO_MPIO], spi_to_mpio);
        queue_compare({name, " miso_oe"}, 16'd0, 16'(spi_miso_oe));
    endtask

    // Sweep of the datapath read port, 1 clk read latency
    task automatic compare_store(string name);
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int t = 0; t < MAX_TAPS; t++) begin
                @(posedge clk);
                rd_filter <= filt_idx_t'(f);
                rd_tap    <= tap_idx_t'(t);
                repeat (2) @(posedge clk);
                queue_compare($sformatf("%s coef[%0d][%0d]", name, f, t), model_coef[f][t],
                              coef_rd);
                if (t == 0)
                    queue_compare($sformatf("%s gain[%0d]", name, f), model_gain[f], gain_rd);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        reg_data_t rx;
        reg_addr_t a;
        spi_cs = 1'b1;
        spi_clk = 1'b0;
        spi_mosi = 1'b0;
        status = '0;
        sram_to_spi_data = '0;
        mpio_to_spi_data = '0;
        rd_filter = '0;
        rd_tap = '0;
        model_regs = '{default: '0};
        model_coef = '{default: '{default: '0}};
        model_gain = '{default: '0};
        model_ptr = 0;
        wait (rst_n === 1'b1);
        repeat (NUM_FILTERS * MAX_TAPS + 4) @(posedge clk);  // Memory clear

        compare_outputs("reset");
        for (int i = 0; i < 16; i++)
            reg_read($sformatf("reset read %0d", i), reg_addr_t'(i));
        compare_store("reset");

        for (int i = 0; i < N_RW_WRITES; i++) begin
            a = RW_ADDRS[$unsigned($random(seed)) % 9];
            reg_write(a, reg_data_t'($random(seed)));
            compare_outputs($sformatf("rw write %0d", i));
            reg_read($sformatf("rw readback %0d", i), a);
        end

        @(posedge clk);
        status           <= reg_data_t'($random(seed));
        sram_to_spi_data <= reg_data_t'($random(seed));
        mpio_to_spi_data <= reg_data_t'($random(seed));
        reg_read("status", ADDR_STATUS);
        reg_read("sram_to_spi", ADDR_SRAM_TO_SPI);
        reg_read("mpio_to_spi", ADDR_MPIO_TO_SPI);
        reg_read("coef lsb", ADDR_FIR_COEF_LSB);
        reg_read("coef msb", ADDR_FIR_COEF_MSB);
        reg_read("eq lsb", ADDR_EQ_GAIN_LSB);
        reg_read("eq msb", ADDR_EQ_GAIN_MSB);
        for (int i = 0; i < N_UNMAPPED; i++) begin
            a = reg_addr_t'(16 + $unsigned($random(seed)) % 112);  // 0x10 to 0x7F
            reg_read($sformatf("unmapped read %h", a), a);
        end
        reg_write(ADDR_STATUS, 8'hFF);
        reg_write(ADDR_SRAM_TO_SPI, 8'hFF);
        reg_write(ADDR_MPIO_TO_SPI, 8'hFF);
        for (int i = 0; i < N_UNMAPPED; i++)
            reg_write(reg_addr_t'(16 + $unsigned($random(seed)) % 112),
                      reg_data_t'($random(seed)));
        compare_outputs("dropped writes");
        compare_store("dropped writes");

        reg_write(ADDR_TAPS_PER_FILTER, reg_data_t'(WRAP_TAPS));
        for (int f = 0; f < NUM_FILTERS; f++) begin
            reg_write(ADDR_FILTER_SEL, reg_data_t'(5 * f));  // Upper bits ignored
            for (int p = 0; p < COEF_PAIRS; p++) begin
                reg_write(ADDR_FIR_COEF_LSB, reg_data_t'($random(seed)));
                reg_write(ADDR_FIR_COEF_MSB, reg_data_t'($random(seed)));
            end
            compare_store($sformatf("coef filter %0d", f));
        end
        reg_write(ADDR_TAPS_PER_FILTER, 8'h00);  // Means MAX_TAPS
        reg_write(ADDR_FILTER_SEL, 8'h03);
        for (int p = 0; p < ZERO_PAIRS; p++) begin
            reg_write(ADDR_FIR_COEF_LSB, reg_data_t'($random(seed)));
            reg_write(ADDR_FIR_COEF_MSB, reg_data_t'($random(seed)));
        end
        compare_store("zero taps");

        for (int f = 0; f < NUM_FILTERS; f++) begin
            reg_write(ADDR_FILTER_SEL, reg_data_t'(f));
            reg_write(ADDR_EQ_GAIN_LSB, reg_data_t'($random(seed)));
            reg_write(ADDR_EQ_GAIN_MSB, reg_data_t'($random(seed)));
        end
        compare_store("eq gain");

        // Aborted after 12 bits, model untouched
        spi_frame({1'b0, ADDR_AUX, ~model_regs[ADDR_AUX]}, 12, rx);
        compare_outputs("aborted aux");
        spi_frame({1'b0, ADDR_FIR_COEF_MSB, 8'h5A}, 12, rx);
        compare_store("aborted coef");

        repeat (4) @(posedge clk);
        while (exp_q.size() != 0)
            @(posedge clk);
        if (errors == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

// Testbench clock, 10 ns period, with synchronous active-low reset
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // Released on a rising edge
    end

endmodule

`default_nettype wire
